//--- include/robCore_params.svh
`ifndef ROBCORE_PARAMS_SVH
`define ROBCORE_PARAMS_SVH

// reorder buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 5     // tag 0 is reserved for "no tag"

// datapath widths
`define DATA_W 32
`define OPC_W 12
`define RD_W 5

`endif

//--- hdl/robPkg.sv
`default_nettype none

`include "robCore_params.svh"

package robPkg;

    // encodings follow the {major, funct} split of the decoder front end
    typedef enum logic [`OPC_W-1:0] {
        opAdd = 12'h020,
        opSub = 12'h022,
        opAnd = 12'h024,
        opOr  = 12'h025,
        opJr  = 12'h008,
        opJ   = 12'h080,
        opJal = 12'h0C0,
        opBeq = 12'h100,
        opBne = 12'h140,
        opLw  = 12'h8C0,
        opSw  = 12'hAC0,
        opHlt = 12'hFC0
    } instOp;

    typedef struct packed {
        logic isBranch;      // entry starts speculative
        logic readyAtIssue;  // no write-back expected
        logic regWrite;
        logic memRead;
        logic memWrite;
    } entryAttr;

endpackage

`default_nettype wire

//--- hdl/cdbIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

interface cdbIf;

    logic [`ROB_TAG_W-1:0] tag;     // 0 means idle
    logic [`DATA_W-1:0]    data;
    logic                  branchTaken;
    logic                  exception;

    modport drv (output tag, output data, output branchTaken, output exception);

    modport rcv (input tag, input data, input branchTaken, input exception);

endinterface

`default_nettype wire

//--- hdl/instDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

module instDecode import robPkg::*; (
    input  wire instOp    opcode,
    output entryAttr      attr
);

    always_comb begin
        attr          = '0;
        attr.regWrite = 1'b1;   // alu default, also covers unknown opcodes

        case (opcode)
            opLw: begin
                attr.memRead = 1'b1;
            end
            opSw: begin
                attr.memWrite = 1'b1;
                attr.regWrite = 1'b0;
            end
            opBeq, opBne: begin
                attr.isBranch = 1'b1;   // waits for the branch decision
                attr.regWrite = 1'b0;
            end
            opJ, opJr: begin
                attr.regWrite = 1'b0;
            end
            opJal, opHlt: begin
                attr.readyAtIssue = 1'b1;   // nothing left to execute
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

module reorderBuffer import robPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  instValid,
    input  wire instOp                 opcode,
    input  wire logic [`DATA_W-1:0]    pc,
    input  wire logic [`RD_W-1:0]      rd,
    input  wire logic                  prediction,
    input  wire logic [`DATA_W-1:0]    branchTarget,
    input  wire entryAttr              attr,
    cdbIf.rcv                          cdbA,
    cdbIf.rcv                          cdbB,
    input  wire logic [`ROB_TAG_W-1:0] readTag1,
    input  wire logic [`ROB_TAG_W-1:0] readTag2,
    output logic [`DATA_W-1:0]         readData1,
    output logic [`DATA_W-1:0]         readData2,
    output logic                       readReady1,
    output logic                       readReady2,
    output logic                       full,
    output logic [`ROB_TAG_W-1:0]      allocTag,
    output logic                       headBusy,
    output logic                       headReady,
    output logic                       headSpec,
    output logic                       headExc,
    output instOp                      headOpcode,
    output logic [`DATA_W-1:0]         headPc,
    output logic [`RD_W-1:0]           headRd,
    output logic [`DATA_W-1:0]         headData,
    output entryAttr                   headAttr,
    input  wire logic                  retire,
    input  wire logic                  flushAll
);

    localparam int IDX_W = `ROB_TAG_W - 1;
    localparam logic [`ROB_TAG_W-1:0] DEPTH = `ROB_DEPTH;

    function automatic logic [IDX_W-1:0] tagIdx(input logic [`ROB_TAG_W-1:0] tag);
        logic [`ROB_TAG_W-1:0] idx;
        idx = tag - 1'b1;           // tags run 1..16
        return idx[IDX_W-1:0];
    endfunction

    function automatic logic [`ROB_TAG_W-1:0] nextPtr(input logic [`ROB_TAG_W-1:0] ptr);
        return (ptr == DEPTH) ? `ROB_TAG_W'(1) : ptr + 1'b1;
    endfunction

    // control state
    logic                  busy [`ROB_DEPTH];
    logic                  ready [`ROB_DEPTH];
    logic                  spec [`ROB_DEPTH];
    logic                  exc [`ROB_DEPTH];
    logic [`ROB_TAG_W-1:0] headPtr;
    logic [`ROB_TAG_W-1:0] tailPtr;
    logic [`ROB_TAG_W-1:0] count;

    // payload
    instOp                 opcodeMem [`ROB_DEPTH];
    logic [`DATA_W-1:0]    pcMem [`ROB_DEPTH];
    logic [`RD_W-1:0]      rdMem [`ROB_DEPTH];
    logic [`DATA_W-1:0]    dataMem [`ROB_DEPTH];
    entryAttr              attrMem [`ROB_DEPTH];
    logic                  predMem [`ROB_DEPTH];

    // both cdb ports flattened so one loop serves them
    logic [`ROB_TAG_W-1:0] wbTag [2];
    logic [`DATA_W-1:0]    wbData [2];
    logic                  wbTaken [2];
    logic                  wbExc [2];
    logic [IDX_W-1:0]      wbIdx [2];
    logic                  wbHit [2];

    logic [IDX_W-1:0]      headIdx;
    logic [IDX_W-1:0]      tailIdx;
    logic                  dispatch;

    assign wbTag[0]   = cdbA.tag;
    assign wbData[0]  = cdbA.data;
    assign wbTaken[0] = cdbA.branchTaken;
    assign wbExc[0]   = cdbA.exception;
    assign wbTag[1]   = cdbB.tag;
    assign wbData[1]  = cdbB.data;
    assign wbTaken[1] = cdbB.branchTaken;
    assign wbExc[1]   = cdbB.exception;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            wbIdx[p] = tagIdx(wbTag[p]);
            wbHit[p] = (wbTag[p] != '0) && busy[wbIdx[p]];  // stale tags are ignored
        end
    end

    assign headIdx  = tagIdx(headPtr);
    assign tailIdx  = tagIdx(tailPtr);
    assign full     = (count == DEPTH);
    assign allocTag = tailPtr;
    assign dispatch = instValid && !full && !flushAll;

    assign readData1  = dataMem[tagIdx(readTag1)];
    assign readData2  = dataMem[tagIdx(readTag2)];
    assign readReady1 = ready[tagIdx(readTag1)];
    assign readReady2 = ready[tagIdx(readTag2)];

    assign headBusy   = busy[headIdx];
    assign headReady  = ready[headIdx];
    assign headSpec   = spec[headIdx];
    assign headExc    = exc[headIdx];
    assign headOpcode = opcodeMem[headIdx];
    assign headPc     = pcMem[headIdx];
    assign headRd     = rdMem[headIdx];
    assign headData   = dataMem[headIdx];
    assign headAttr   = attrMem[headIdx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                busy[i]  <= 1'b0;
                ready[i] <= 1'b0;
                spec[i]  <= 1'b0;
                exc[i]   <= 1'b0;
            end
            headPtr <= `ROB_TAG_W'(1);
            tailPtr <= `ROB_TAG_W'(1);
            count   <= '0;
        end else if (flushAll) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
            end
            headPtr <= `ROB_TAG_W'(1);
            tailPtr <= `ROB_TAG_W'(1);
            count   <= '0;
        end else begin
            if (dispatch) begin
                busy[tailIdx]  <= 1'b1;
                ready[tailIdx] <= attr.readyAtIssue;
                spec[tailIdx]  <= attr.isBranch;
                exc[tailIdx]   <= 1'b0;
                tailPtr        <= nextPtr(tailPtr);
            end
            for (int p = 0; p < 2; p++) begin
                if (wbHit[p]) begin
                    // correct prediction drops speculation, a miss keeps it for the flush
                    spec[wbIdx[p]]  <= spec[wbIdx[p]] & (wbTaken[p] ^ predMem[wbIdx[p]]);
                    ready[wbIdx[p]] <= 1'b1;
                    exc[wbIdx[p]]   <= wbExc[p];
                end
            end
            if (retire) begin
                busy[headIdx] <= 1'b0;
                headPtr       <= nextPtr(headPtr);
            end
            case ({dispatch, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            opcodeMem[tailIdx] <= opcode;
            pcMem[tailIdx]     <= pc;
            rdMem[tailIdx]     <= rd;
            attrMem[tailIdx]   <= attr;
            predMem[tailIdx]   <= prediction;
            dataMem[tailIdx]   <= branchTarget;   // branches keep their target
        end
        for (int p = 0; p < 2; p++) begin
            if (wbHit[p] && !spec[wbIdx[p]]) begin
                dataMem[wbIdx[p]] <= wbData[p];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
        else $error("entry count above buffer depth");

    // the commit decision must pick one action per head
    assert property (@(posedge clk) disable iff (rst) !(retire && flushAll))
        else $error("retire and flush requested together");

endmodule

`default_nettype wire

//--- hdl/commitUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

module commitUnit import robPkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               headBusy,
    input  wire logic               headReady,
    input  wire logic               headSpec,
    input  wire logic               headExc,
    input  wire instOp              headOpcode,
    input  wire logic [`DATA_W-1:0] headPc,
    input  wire logic [`RD_W-1:0]   headRd,
    input  wire logic [`DATA_W-1:0] headData,
    input  wire entryAttr           headAttr,
    output logic                    retire,
    output logic                    flushAll,
    output logic                    commitValid,
    output logic [`OPC_W-1:0]       commitOpcode,
    output logic [`DATA_W-1:0]      commitPc,
    output logic [`RD_W-1:0]        commitRd,
    output logic [`DATA_W-1:0]      commitData,
    output logic                    commitRegWrite,
    output logic                    commitMemRead,
    output logic                    commitMemWrite,
    output logic                    flush,
    output logic                    wrongPrediction
);

    logic mispredict;
    logic excFlush;

    assign retire     = headBusy && headReady && !headSpec && !headExc;
    assign mispredict = headBusy && headReady && headSpec;   // still speculative after resolve
    assign excFlush   = headBusy && headExc && !headSpec;
    assign flushAll   = mispredict || excFlush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitValid     <= 1'b0;
            commitOpcode    <= '0;
            commitPc        <= '0;
            commitRd        <= '0;
            commitData      <= '0;
            commitRegWrite  <= 1'b0;
            commitMemRead   <= 1'b0;
            commitMemWrite  <= 1'b0;
            flush           <= 1'b0;
            wrongPrediction <= 1'b0;
        end else begin
            commitValid     <= retire;
            commitOpcode    <= (retire || flushAll) ? headOpcode : '0;
            commitPc        <= (retire || excFlush) ? headPc : '0;
            commitRd        <= retire ? headRd : '0;
            commitData      <= (retire || mispredict) ? headData : '0;  // target on a miss
            commitRegWrite  <= retire && headAttr.regWrite;
            commitMemRead   <= retire && headAttr.memRead;
            commitMemWrite  <= retire && headAttr.memWrite;
            flush           <= flushAll;
            wrongPrediction <= mispredict;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(commitValid && flush))
        else $error("commit and flush reported in the same cycle");

endmodule

`default_nettype wire

//--- hdl/robCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

module robCore import robPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  instValid,
    input  wire logic [`OPC_W-1:0]     instOpcode,
    input  wire logic [`DATA_W-1:0]    instPc,
    input  wire logic [`RD_W-1:0]      instRd,
    input  wire logic                  prediction,
    input  wire logic [`DATA_W-1:0]    branchTarget,
    input  wire logic [`ROB_TAG_W-1:0] cdb1Tag,
    input  wire logic [`DATA_W-1:0]    cdb1Data,
    input  wire logic                  cdb1Taken,
    input  wire logic                  cdb1Exception,
    input  wire logic [`ROB_TAG_W-1:0] cdb2Tag,
    input  wire logic [`DATA_W-1:0]    cdb2Data,
    input  wire logic                  cdb2Taken,
    input  wire logic                  cdb2Exception,
    input  wire logic [`ROB_TAG_W-1:0] readTag1,
    input  wire logic [`ROB_TAG_W-1:0] readTag2,
    output logic [`DATA_W-1:0]         readData1,
    output logic [`DATA_W-1:0]         readData2,
    output logic                       readReady1,
    output logic                       readReady2,
    output logic                       full,
    output logic [`ROB_TAG_W-1:0]      allocTag,
    output logic                       commitValid,
    output logic [`OPC_W-1:0]          commitOpcode,
    output logic [`DATA_W-1:0]         commitPc,
    output logic [`RD_W-1:0]           commitRd,
    output logic [`DATA_W-1:0]         commitData,
    output logic                       commitRegWrite,
    output logic                       commitMemRead,
    output logic                       commitMemWrite,
    output logic                       flush,
    output logic                       wrongPrediction
);

    entryAttr              decAttr;
    logic                  headBusy;
    logic                  headReady;
    logic                  headSpec;
    logic                  headExc;
    instOp                 headOpcode;
    logic [`DATA_W-1:0]    headPc;
    logic [`RD_W-1:0]      headRd;
    logic [`DATA_W-1:0]    headData;
    entryAttr              headAttr;
    logic                  retire;
    logic                  flushAll;

    cdbIf cdbPort1 ();
    cdbIf cdbPort2 ();

    assign cdbPort1.tag         = cdb1Tag;
    assign cdbPort1.data        = cdb1Data;
    assign cdbPort1.branchTaken = cdb1Taken;
    assign cdbPort1.exception   = cdb1Exception;
    assign cdbPort2.tag         = cdb2Tag;
    assign cdbPort2.data        = cdb2Data;
    assign cdbPort2.branchTaken = cdb2Taken;
    assign cdbPort2.exception   = cdb2Exception;

    instDecode uDecode (
        .opcode (instOp'(instOpcode)),   // unknown codes pass through as alu
        .attr   (decAttr)
    );

    reorderBuffer uRob (
        .clk          (clk),
        .rst          (rst),
        .instValid    (instValid),
        .opcode       (instOp'(instOpcode)),
        .pc           (instPc),
        .rd           (instRd),
        .prediction   (prediction),
        .branchTarget (branchTarget),
        .attr         (decAttr),
        .cdbA         (cdbPort1.rcv),
        .cdbB         (cdbPort2.rcv),
        .readTag1     (readTag1),
        .readTag2     (readTag2),
        .readData1    (readData1),
        .readData2    (readData2),
        .readReady1   (readReady1),
        .readReady2   (readReady2),
        .full         (full),
        .allocTag     (allocTag),
        .headBusy     (headBusy),
        .headReady    (headReady),
        .headSpec     (headSpec),
        .headExc      (headExc),
        .headOpcode   (headOpcode),
        .headPc       (headPc),
        .headRd       (headRd),
        .headData     (headData),
        .headAttr     (headAttr),
        .retire       (retire),
        .flushAll     (flushAll)
    );

    commitUnit uCommit (
        .clk             (clk),
        .rst             (rst),
        .headBusy        (headBusy),
        .headReady       (headReady),
        .headSpec        (headSpec),
        .headExc         (headExc),
        .headOpcode      (headOpcode),
        .headPc          (headPc),
        .headRd          (headRd),
        .headData        (headData),
        .headAttr        (headAttr),
        .retire          (retire),
        .flushAll        (flushAll),
        .commitValid     (commitValid),
        .commitOpcode    (commitOpcode),
        .commitPc        (commitPc),
        .commitRd        (commitRd),
        .commitData      (commitData),
        .commitRegWrite  (commitRegWrite),
        .commitMemRead   (commitMemRead),
        .commitMemWrite  (commitMemWrite),
        .flush           (flush),
        .wrongPrediction (wrongPrediction)
    );

endmodule

`default_nettype wire

//--- test/robChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

module robChecker import robPkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  instValid,
    input  wire logic [`OPC_W-1:0]     instOpcode,
    input  wire logic [`DATA_W-1:0]    instPc,
    input  wire logic [`RD_W-1:0]      instRd,
    input  wire logic                  prediction,
    input  wire logic [`DATA_W-1:0]    branchTarget,
    input  wire logic [`ROB_TAG_W-1:0] cdb1Tag,
    input  wire logic [`DATA_W-1:0]    cdb1Data,
    input  wire logic                  cdb1Taken,
    input  wire logic                  cdb1Exception,
    input  wire logic [`ROB_TAG_W-1:0] cdb2Tag,
    input  wire logic [`DATA_W-1:0]    cdb2Data,
    input  wire logic                  cdb2Taken,
    input  wire logic                  cdb2Exception,
    input  wire logic [`ROB_TAG_W-1:0] readTag1,
    input  wire logic [`ROB_TAG_W-1:0] readTag2,
    input  wire logic [`DATA_W-1:0]    readData1,
    input  wire logic [`DATA_W-1:0]    readData2,
    input  wire logic                  readReady1,
    input  wire logic                  readReady2,
    input  wire logic                  full,
    input  wire logic [`ROB_TAG_W-1:0] allocTag,
    input  wire logic                  commitValid,
    input  wire logic [`OPC_W-1:0]     commitOpcode,
    input  wire logic [`DATA_W-1:0]    commitPc,
    input  wire logic [`RD_W-1:0]      commitRd,
    input  wire logic [`DATA_W-1:0]    commitData,
    input  wire logic                  commitRegWrite,
    input  wire logic                  commitMemRead,
    input  wire logic                  commitMemWrite,
    input  wire logic                  flush,
    input  wire logic                  wrongPrediction,
    output int                         errCount,
    output logic                       modelEmpty
);

    // model queue where slot i holds tag i+1
    logic               busy [`ROB_DEPTH];
    logic               ready [`ROB_DEPTH];
    logic               spec [`ROB_DEPTH];
    logic               exc [`ROB_DEPTH];
    logic               entPred [`ROB_DEPTH];
    logic [`OPC_W-1:0]  entOpc [`ROB_DEPTH];
    logic [`DATA_W-1:0] entPc [`ROB_DEPTH];
    logic [`RD_W-1:0]   entRd [`ROB_DEPTH];
    logic [`DATA_W-1:0] entData [`ROB_DEPTH];
    int                 head;
    int                 tail;
    int                 count;
    int                 errors = 0;

    // expected registered commit outputs
    logic               expValid;
    logic [`OPC_W-1:0]  expOpcode;
    logic [`DATA_W-1:0] expPc;
    logic [`RD_W-1:0]   expRd;
    logic [`DATA_W-1:0] expData;
    logic               expRegWrite;
    logic               expMemRead;
    logic               expMemWrite;
    logic               expFlush;
    logic               expWrong;

    assign errCount   = errors;
    assign modelEmpty = (count == 0);

    function automatic int slotOf(input logic [`ROB_TAG_W-1:0] tag);
        return (int'(tag) + `ROB_DEPTH - 1) % `ROB_DEPTH;   // tag 0 aliases the last slot
    endfunction

    function automatic logic writesReg(input logic [`OPC_W-1:0] op);
        return !(op == opJr || op == opSw || op == opBeq || op == opBne || op == opJ);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s at %0t: dut %h model %h", name, $time, got, exp);
        end
    endtask

    always @(posedge clk or posedge rst) begin
        logic [`ROB_TAG_W-1:0] wTag [2];
        logic [`DATA_W-1:0]    wData [2];
        logic                  wTaken [2];
        logic                  wExc [2];
        logic                  wHit [2];
        logic                  oldSpec [`ROB_DEPTH];
        logic                  retire;
        logic                  mispredict;
        logic                  excFlush;
        logic                  doFlush;
        logic                  accept;
        int                    s;
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                busy[i]  = 1'b0;
                ready[i] = 1'b0;
                spec[i]  = 1'b0;
                exc[i]   = 1'b0;
            end
            head        = 0;
            tail        = 0;
            count       = 0;
            expValid    = 1'b0;
            expOpcode   = '0;
            expPc       = '0;
            expRd       = '0;
            expData     = '0;
            expRegWrite = 1'b0;
            expMemRead  = 1'b0;
            expMemWrite = 1'b0;
            expFlush    = 1'b0;
            expWrong    = 1'b0;
        end else begin
            wTag[0]   = cdb1Tag;
            wData[0]  = cdb1Data;
            wTaken[0] = cdb1Taken;
            wExc[0]   = cdb1Exception;
            wTag[1]   = cdb2Tag;
            wData[1]  = cdb2Data;
            wTaken[1] = cdb2Taken;
            wExc[1]   = cdb2Exception;
            oldSpec   = spec;

            // retire wins over both flush kinds
            retire     = busy[head] && ready[head] && !spec[head] && !exc[head];
            mispredict = busy[head] && ready[head] && spec[head];
            excFlush   = busy[head] && exc[head] && !spec[head];
            doFlush    = mispredict || excFlush;
            accept     = instValid && (count < `ROB_DEPTH) && !doFlush;

            expValid    = retire;
            expOpcode   = (retire || doFlush) ? entOpc[head] : '0;
            expPc       = (retire || excFlush) ? entPc[head] : '0;
            expRd       = retire ? entRd[head] : '0;
            expData     = (retire || mispredict) ? entData[head] : '0;
            expRegWrite = retire && writesReg(entOpc[head]);
            expMemRead  = retire && (entOpc[head] == opLw);
            expMemWrite = retire && (entOpc[head] == opSw);
            expFlush    = doFlush;
            expWrong    = mispredict;

            for (int p = 0; p < 2; p++) begin
                wHit[p] = (wTag[p] != '0) && busy[slotOf(wTag[p])];
            end
            if (accept) begin
                entOpc[tail]  = instOpcode;
                entPc[tail]   = instPc;
                entRd[tail]   = instRd;
                entPred[tail] = prediction;
                entData[tail] = branchTarget;   // target stays for branches
            end
            for (int p = 0; p < 2; p++) begin
                s = slotOf(wTag[p]);
                if (wHit[p] && !oldSpec[s]) begin
                    entData[s] = wData[p];      // lands even on a flush edge
                end
            end

            if (doFlush) begin
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    busy[i] = 1'b0;             // ready bits survive a flush
                end
                head  = 0;
                tail  = 0;
                count = 0;
            end else begin
                if (accept) begin
                    busy[tail]  = 1'b1;
                    ready[tail] = (instOpcode == opHlt) || (instOpcode == opJal);
                    spec[tail]  = (instOpcode == opBeq) || (instOpcode == opBne);
                    exc[tail]   = 1'b0;
                    tail        = (tail + 1) % `ROB_DEPTH;
                    count++;
                end
                for (int p = 0; p < 2; p++) begin
                    s = slotOf(wTag[p]);
                    if (wHit[p]) begin
                        spec[s]  = oldSpec[s] && (wTaken[p] != entPred[s]);
                        ready[s] = 1'b1;
                        exc[s]   = wExc[p];
                    end
                end
                if (retire) begin
                    busy[head] = 1'b0;
                    head       = (head + 1) % `ROB_DEPTH;
                    count--;
                end
            end
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (!rst) begin
            compare("full", full, count == `ROB_DEPTH);
            compare("allocTag", allocTag, tail + 1);
            compare("readReady1", readReady1, ready[slotOf(readTag1)]);
            compare("readReady2", readReady2, ready[slotOf(readTag2)]);
            compare("readData1", readData1, entData[slotOf(readTag1)]);
            compare("readData2", readData2, entData[slotOf(readTag2)]);
            compare("commitValid", commitValid, expValid);
            compare("commitOpcode", commitOpcode, expOpcode);
            compare("commitPc", commitPc, expPc);
            compare("commitRd", commitRd, expRd);
            compare("commitData", commitData, expData);
            compare("commitRegWrite", commitRegWrite, expRegWrite);
            compare("commitMemRead", commitMemRead, expMemRead);
            compare("commitMemWrite", commitMemWrite, expMemWrite);
            compare("flush", flush, expFlush);
            compare("wrongPrediction", wrongPrediction, expWrong);
        end
    end

endmodule

`default_nettype wire

//--- test/robTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "robCore_params.svh"

module robTb import robPkg::*; ();

    localparam int STIM_CYCLES  = 2000;
    localparam int DRAIN_CYCLES = 24;       // one retire per cycle empties 16 entries
    localparam int MAX_CYCLES   = STIM_CYCLES + 1000;
    localparam int PHASE_LEN    = 200;      // alternates fast and slow write-back

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  instValid;
    logic [`OPC_W-1:0]     instOpcode;
    logic [`DATA_W-1:0]    instPc;
    logic [`RD_W-1:0]      instRd;
    logic                  prediction;
    logic [`DATA_W-1:0]    branchTarget;
    logic [`ROB_TAG_W-1:0] cdb1Tag;
    logic [`DATA_W-1:0]    cdb1Data;
    logic                  cdb1Taken;
    logic                  cdb1Exception;
    logic [`ROB_TAG_W-1:0] cdb2Tag;
    logic [`DATA_W-1:0]    cdb2Data;
    logic                  cdb2Taken;
    logic                  cdb2Exception;
    logic [`ROB_TAG_W-1:0] readTag1;
    logic [`ROB_TAG_W-1:0] readTag2;
    logic [`DATA_W-1:0]    readData1;
    logic [`DATA_W-1:0]    readData2;
    logic                  readReady1;
    logic                  readReady2;
    logic                  full;
    logic [`ROB_TAG_W-1:0] allocTag;
    logic                  commitValid;
    logic [`OPC_W-1:0]     commitOpcode;
    logic [`DATA_W-1:0]    commitPc;
    logic [`RD_W-1:0]      commitRd;
    logic [`DATA_W-1:0]    commitData;
    logic                  commitRegWrite;
    logic                  commitMemRead;
    logic                  commitMemWrite;
    logic                  flush;
    logic                  wrongPrediction;

    logic [31:0]           lcgState;
    logic [`ROB_TAG_W-1:0] pending [$];    // dispatched tags still owed a write-back
    int                    cycleCount = 0;
    int                    tbErrors = 0;
    int                    checkErrors;
    logic                  modelEmpty;
    int                    commits = 0;
    int                    mispredicts = 0;
    int                    excFlushes = 0;
    int                    fullCycles = 0;

    instOp opList [12] = '{opAdd, opSub, opAnd, opOr, opLw, opSw,
                           opBeq, opBne, opJ, opJal, opJr, opHlt};

    always #20 clk = ~clk;

    robCore u_dut (.*);

    robChecker uChecker (.*, .errCount(checkErrors), .modelEmpty(modelEmpty));

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];     // low bits of the lcg cycle too quickly
    endfunction

    function automatic int below(input int n);
        return int'(nextRand()) % n;
    endfunction

    function automatic logic coin();
        logic [15:0] r;
        r = nextRand();
        return r[15];
    endfunction

    task automatic pickWriteBack(input int odds, output logic [`ROB_TAG_W-1:0] tag,
                                 output logic [`DATA_W-1:0] data, output logic taken,
                                 output logic exc);
        int k;
        tag   = '0;
        data  = '0;
        taken = 1'b0;
        exc   = 1'b0;
        if (pending.size() > 0 && below(16) < odds) begin
            k     = below(pending.size());
            tag   = pending[k];
            pending.delete(k);
            data  = {nextRand(), nextRand()};
            taken = coin();
            exc   = (below(32) == 0);   // rare exception
        end
    endtask

    task automatic driveCycle(input logic allowDispatch);
        logic slow;
        int   wbOdds;
        instOp opc;
        @(posedge clk);
        #2;
        if (flush) begin
            pending.delete();               // everything in flight was squashed
        end
        slow   = allowDispatch && ((cycleCount / PHASE_LEN) % 2 == 1);
        wbOdds = slow ? 1 : 12;
        // write-backs are picked before the new tag joins the list
        pickWriteBack(wbOdds, cdb1Tag, cdb1Data, cdb1Taken, cdb1Exception);
        pickWriteBack(wbOdds, cdb2Tag, cdb2Data, cdb2Taken, cdb2Exception);
        opc          = opList[below(12)];
        instValid    = allowDispatch && (below(4) < (slow ? 3 : 2));
        instOpcode   = opc;
        instPc       = {nextRand(), nextRand()};
        instRd       = `RD_W'(nextRand());
        prediction   = coin();
        branchTarget = {nextRand(), nextRand()};
        readTag1     = `ROB_TAG_W'(1 + below(`ROB_DEPTH));
        readTag2     = `ROB_TAG_W'(1 + below(`ROB_DEPTH));
        if (instValid && !full && opc != opHlt && opc != opJal) begin
            pending.push_back(allocTag);
        end
    endtask

    task automatic finishRun();
        int total;
        if (!modelEmpty) begin
            tbErrors++;
            $display("buffer still holds entries after the drain");
        end
        if (fullCycles == 0) begin
            tbErrors++;
            $display("the buffer never became full");
        end
        if (mispredicts == 0 || excFlushes == 0) begin
            tbErrors++;
            $display("stimulus produced no mispredict flush or no exception flush");
        end
        total = tbErrors + checkErrors;
        $display("errors %0d (checker %0d, testbench %0d) commits %0d mispredicts %0d exc %0d",
                 total, checkErrors, tbErrors, commits, mispredicts, excFlushes);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            commits     += int'(commitValid);
            mispredicts += int'(wrongPrediction);
            excFlushes  += int'(flush && !wrongPrediction);
            fullCycles  += int'(full);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        lcgState      = 32'd82932;
        rst           = 1'b1;
        instValid     = 1'b0;
        instOpcode    = '0;
        instPc        = '0;
        instRd        = '0;
        prediction    = 1'b0;
        branchTarget  = '0;
        cdb1Tag       = '0;
        cdb1Data      = '0;
        cdb1Taken     = 1'b0;
        cdb1Exception = 1'b0;
        cdb2Tag       = '0;
        cdb2Data      = '0;
        cdb2Taken     = 1'b0;
        cdb2Exception = 1'b0;
        readTag1      = `ROB_TAG_W'(1);
        readTag2      = `ROB_TAG_W'(1);
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            driveCycle(1'b1);
        end
        while (pending.size() > 0) begin
            driveCycle(1'b0);
        end
        repeat (DRAIN_CYCLES) driveCycle(1'b0);
        finishRun();
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hdl/robPkg.sv
hdl/cdbIf.sv
hdl/instDecode.sv
hdl/reorderBuffer.sv
hdl/commitUnit.sv
hdl/robCore.sv
test/robChecker.sv
test/robTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = robTb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
